//--- fpu.f
+incdir+.
fpu_pkg.sv
fp_unpack.sv
fp_addsub.sv
fp_to_int.sv
fpu_wb_regs.sv
fpu_top.sv
tb_fpu.sv

//--- run.sh
#!/bin/sh
# build and run the fpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_fpu -f fpu.f -o tb_fpu || exit 1

sim_out=$(./obj_dir/tb_fpu)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully" && echo "PASS" || {
  echo "FAIL"
  exit 1
}

//--- tb_fpu.sv
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module tb_fpu;

  localparam int WB = 300;  // wide enough for any two binary32 values on one scale

  logic                clk;
  logic                arst_n;
  fpu_pkg::wb_req_t    wb_req;
  fpu_pkg::wb_rsp_t    wb_rsp;
  integer              seed;
  int                  n_pass;
  int                  n_fail;
  int                  base_pass;  // counts at the start of the running test
  int                  base_fail;
  event                bus_hung;   // an access never got its ack

  fpu_top UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // exact sum on a common scale, then one rounding to binary32
  // returns {overflow, invalid, word}
  function automatic logic [33:0] model_addsub(input logic [31:0] a, b, input logic sub);
    logic                 sb;
    logic [7:0]           ea;
    logic [7:0]           eb;
    logic [23:0]          ma;
    logic [23:0]          mb;
    int                   ka;
    int                   kb;
    int                   e0;
    int                   p;
    int                   be;
    int                   sh;
    logic signed [WB-1:0] va;
    logic signed [WB-1:0] vb;
    logic signed [WB-1:0] s;
    logic [WB-1:0]        mag;
    logic [WB-1:0]        rem;
    logic [WB-1:0]        half;
    logic [WB-1:0]        q;
    logic                 sr;
    sb = b[31] ^ sub;
    ea = a[30:23];
    eb = b[30:23];
    if ((ea == 8'hff && a[22:0] != 0) || (eb == 8'hff && b[22:0] != 0))
      return {2'b01, `FPU_QNAN};
    if (ea == 8'hff && eb == 8'hff && a[31] != sb)
      return {2'b01, `FPU_QNAN};  // opposite infinities
    if (ea == 8'hff)
      return {2'b00, a[31], 8'hff, 23'd0};
    if (eb == 8'hff)
      return {2'b00, sb, 8'hff, 23'd0};
    ka = (ea == 0) ? 1 : ea;  // value = m * 2^(k-150)
    kb = (eb == 0) ? 1 : eb;
    ma = {ea != 0, a[22:0]};
    mb = {eb != 0, b[22:0]};
    e0 = (ka < kb) ? ka : kb;
    va = WB'(ma) << (ka - e0);
    vb = WB'(mb) << (kb - e0);
    if (a[31]) va = -va;
    if (sb) vb = -vb;
    s = va + vb;
    if (s == 0)
      return 34'd0;  // exact zero is +0
    sr  = s[WB-1];
    mag = sr ? -s : s;
    p   = 0;
    for (int i = 0; i < WB; i++) begin
      if (mag[i]) p = i;  // msb position
    end
    be = e0 + p - 23;
    if (be < 1) be = 1;  // subnormal range
    sh = be - e0;
    if (sh <= 0) begin
      q = mag << (-sh);  // exact, nothing to round
    end else begin
      q    = mag >> sh;
      rem  = mag & ((WB'(1) << sh) - WB'(1));
      half = WB'(1) << (sh - 1);
      if (rem > half || (rem == half && q[0])) q = q + WB'(1);
    end
    if (q[24]) begin
      q  = q >> 1;  // rounding reached 2^24
      be = be + 1;
    end
    if (be >= 255)
      return {2'b10, sr, 8'hff, 23'd0};
    return {2'b00, sr, q[23] ? 8'(be) : 8'd0, q[22:0]};
  endfunction

  // truncating conversion, returns {invalid, word}
  function automatic logic [32:0] model_to_int(input logic [31:0] a);
    logic [7:0]  e;
    logic [23:0] m;
    logic [63:0] mag;
    int          sc;
    e = a[30:23];
    if (e == 8'hff && a[22:0] != 0)
      return {1'b1, 32'd0};
    if (e == 8'hff)
      return {1'b0, a[31] ? `FPU_INT_MIN : `FPU_INT_MAX};
    m  = {e != 0, a[22:0]};
    sc = ((e == 0) ? 1 : int'(e)) - 150;
    if (sc > 16) mag = 64'h1_0000_0000;  // far beyond 2^31
    else if (sc >= 0) mag = 64'(m) << sc;
    else if (sc > -64) mag = 64'(m) >> (-sc);
    else mag = 64'd0;
    if (mag >= 64'h8000_0000)
      return {1'b0, a[31] ? `FPU_INT_MIN : `FPU_INT_MAX};
    return {1'b0, a[31] ? -mag[31:0] : mag[31:0]};
  endfunction

  // exponent mix leans on the edges of the format
  function automatic logic [31:0] rand_float(input logic [7:0] near);
    logic [7:0]  e;
    logic [22:0] m;
    int          sel;
    int          msel;
    sel  = {$random(seed)} % 16;
    msel = {$random(seed)} % 8;
    e    = 8'($random(seed));
    m    = 23'($random(seed));
    case (sel)
      0:          e = 8'd0;    // zero or subnormal
      1:          e = 8'd255;  // inf or nan
      2:          e = 8'd254;
      3, 4, 5, 6: e = near + 8'({$random(seed)} % 3) - 8'd1;
      7, 8:       e = near;
      default: ;
    endcase
    if (msel == 0) m = '0;
    if (msel == 1) m[10:0] = '0;  // short mantissa, more ties
    return {1'($random(seed)), e, m};
  endfunction

  function automatic logic [31:0] rand_conv_src();
    logic [7:0]  e;
    logic [22:0] m;
    int          sel;
    sel = {$random(seed)} % 8;
    m   = 23'($random(seed));
    case (sel)
      0:       e = 8'd255;
      1:       e = 8'd158;  // 2^31
      2:       e = 8'd157;
      3:       e = 8'({$random(seed)} % 127);  // |x| < 1
      default: e = 8'd127 + 8'({$random(seed)} % 32);
    endcase
    if ({$random(seed)} % 8 == 0) m = '0;
    return {1'($random(seed)), e, m};
  endfunction

  task automatic gen_pair(output logic [31:0] a, output logic [31:0] b);
    logic [7:0] near;
    near = ({$random(seed)} % 4 == 0) ? 8'd2 : 8'($random(seed));  // low exponents now and then
    a = rand_float(near);
    b = rand_float(a[30:23]);
    if ({$random(seed)} % 16 == 0) b = {1'($random(seed)), a[30:0]};  // cancel or double
  endtask

  task automatic end_run();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // a hung bus access ends the run from here
  initial begin
    @(bus_hung);
    end_run();
  end

  // called 1 ns after an edge, returns 1 ns after the acking edge
  task automatic wait_ack(input logic [2:0] addr);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      #1;
      cnt++;
    end while (!wb_rsp.ack && cnt < 50);
    if (!wb_rsp.ack) begin
      $display("bus access to word %0d was not acknowledged within 50 cycles", addr);
      n_fail++;
      -> bus_hung;
      @(posedge clk);
    end
  endtask

  task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b1;
    wb_req.adr   = addr;
    wb_req.dat_w = data;
    wait_ack(addr);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = addr;
    wait_ack(addr);
    data       = wb_rsp.dat_r;  // stable until the next edge
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, exp,
                            input logic [31:0] a, b);
    assert (got === exp) n_pass++;
    else begin
      $display("mismatch %s got %h expected %h (a %h b %h)", name, got, exp, a, b);
      n_fail++;
    end
  endtask

  task automatic exec_and_check(input logic [31:0] a, b, input logic [1:0] op,
                                input logic [31:0] exp_res, exp_stat);
    logic [31:0] res;
    logic [31:0] stat;
    wb_write(`FPU_REG_A, a);
    wb_write(`FPU_REG_B, b);
    wb_write(`FPU_REG_OP, {30'd0, op});
    wb_read(`FPU_REG_RES, res);  // stalls while the job is in flight
    wb_read(`FPU_REG_STAT, stat);
    check_word("RESULT", res, exp_res, a, b);
    check_word("STATUS", stat, exp_stat, a, b);
  endtask

  task automatic check_arith(input logic [31:0] a, b, input logic [1:0] op);
    logic [33:0] m;
    m = model_addsub(a, b, op == 2'(fpu_pkg::op_sub));
    exec_and_check(a, b, op, m[31:0], {29'd0, m[33], m[32], 1'b0});  // busy expected low
  endtask

  task automatic check_conv(input logic [31:0] a);
    logic [32:0] m;
    m = model_to_int(a);
    exec_and_check(a, 32'd0, 2'(fpu_pkg::op_float_to_int), m[31:0], {30'd0, m[32], 1'b0});
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d errors", name,
             n_pass + n_fail - base_pass - base_fail, n_fail - base_fail);
    base_pass = n_pass;
    base_fail = n_fail;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    seed      = 32'h1cca_8395;
    n_pass    = 0;
    n_fail    = 0;
    base_pass = 0;
    base_fail = 0;
    wb_req    = '0;
    arst_n    = 1'b0;
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;

    wb_read(`FPU_REG_STAT, w);
    check_word("STATUS", w, 32'd0, 32'd0, 32'd0);
    wb_read(`FPU_REG_RES, w);
    check_word("RESULT", w, 32'd0, 32'd0, 32'd0);
    report_test("reset");

    repeat (200) begin
      gen_pair(a, b);
      check_arith(a, b, 2'(fpu_pkg::op_add));
    end
    report_test("random add");

    repeat (200) begin
      gen_pair(a, b);
      check_arith(a, b, 2'(fpu_pkg::op_sub));
    end
    report_test("random sub");

    // nan, inf and overflow rules, expected words written out
    exec_and_check(32'h7F80_0001, 32'h3F80_0000, 2'd0, `FPU_QNAN, 32'h2);
    exec_and_check(32'h3F80_0000, 32'hFFC1_2345, 2'd1, `FPU_QNAN, 32'h2);
    exec_and_check(32'h7F80_0000, 32'hFF80_0000, 2'd0, `FPU_QNAN, 32'h2);
    exec_and_check(32'h7F80_0000, 32'h7F80_0000, 2'd1, `FPU_QNAN, 32'h2);
    exec_and_check(32'h7F80_0000, 32'h3F80_0000, 2'd0, 32'h7F80_0000, 32'h0);
    exec_and_check(32'hC200_0000, 32'h7F80_0000, 2'd1, 32'hFF80_0000, 32'h0);
    exec_and_check(32'hFF80_0000, 32'hFF80_0000, 2'd0, 32'hFF80_0000, 32'h0);
    exec_and_check(32'h7F7F_FFFF, 32'h7F7F_FFFF, 2'd0, 32'h7F80_0000, 32'h4);
    exec_and_check(32'hFF7F_FFFF, 32'h7F7F_FFFF, 2'd1, 32'hFF80_0000, 32'h4);
    exec_and_check(32'h7F7F_FFFF, 32'h7300_0000, 2'd0, 32'h7F80_0000, 32'h4);  // tie to odd max
    exec_and_check(32'h3F80_0000, 32'h3F80_0000, 2'd1, 32'h0000_0000, 32'h0);
    exec_and_check(32'h8000_0000, 32'h8000_0000, 2'd0, 32'h0000_0000, 32'h0);
    report_test("special cases");

    exec_and_check(32'h7FC0_0000, 32'd0, 2'd2, 32'h0000_0000, 32'h2);
    exec_and_check(32'h4F00_0000, 32'd0, 2'd2, 32'h7FFF_FFFF, 32'h0);
    exec_and_check(32'hCF00_0000, 32'd0, 2'd2, 32'h8000_0000, 32'h0);
    exec_and_check(32'hCEFF_FFFF, 32'd0, 2'd2, 32'h8000_0080, 32'h0);
    exec_and_check(32'hFF80_0000, 32'd0, 2'd2, 32'h8000_0000, 32'h0);
    exec_and_check(32'h3F7F_FFFF, 32'd0, 2'd2, 32'h0000_0000, 32'h0);
    exec_and_check(32'hBFC0_0000, 32'd0, 2'd2, 32'hFFFF_FFFF, 32'h0);
    repeat (100) begin
      check_conv(rand_conv_src());
    end
    report_test("float to int");

    // a new op right after the last one, result read straight away
    exec_and_check(32'h3F80_0000, 32'h4000_0000, 2'd0, 32'h4040_0000, 32'h0);
    wb_write(`FPU_REG_OP, 32'(fpu_pkg::op_sub));
    wb_read(`FPU_REG_RES, w);
    check_word("RESULT", w, 32'hBF80_0000, 32'h3F80_0000, 32'h4000_0000);
    wb_write(`FPU_REG_OP, 32'(fpu_pkg::op_add));
    wb_write(`FPU_REG_OP, 32'(fpu_pkg::op_float_to_int));  // held off while busy
    wb_read(`FPU_REG_RES, w);
    check_word("RESULT", w, 32'h0000_0001, 32'h3F80_0000, 32'h4000_0000);
    wb_read(`FPU_REG_STAT, w);
    check_word("STATUS", w & 32'h1, 32'h0, 32'h3F80_0000, 32'h4000_0000);
    report_test("back to back");

    end_run();
  end

endmodule

//--- fpu_top.sv
`timescale 1ns/1ps

module fpu_top (
  input  logic             clk,
  input  logic             arst_n,
  input  fpu_pkg::wb_req_t wb_req,
  output fpu_pkg::wb_rsp_t wb_rsp
);

  fpu_pkg::fpu_job_t     job;
  fpu_pkg::fp_unpacked_t unp_a;
  fpu_pkg::fp_unpacked_t unp_b;
  fpu_pkg::fp_word_u     addsub_res;
  fpu_pkg::fpu_flags_t   addsub_flags;
  fpu_pkg::fp_word_u     conv_res;
  fpu_pkg::fpu_flags_t   conv_flags;

  // bus side, operand and job registers
  fpu_wb_regs u_wb_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .job          (job),
    .addsub_res   (addsub_res),
    .addsub_flags (addsub_flags),
    .conv_res     (conv_res),
    .conv_flags   (conv_flags)
  );

  fp_unpack u_unpack_a (
    .op_word (job.a),
    .unp     (unp_a)
  );

  fp_unpack u_unpack_b (
    .op_word (job.b),
    .unp     (unp_b)
  );

  // combinational core, one cycle from job register to result register
  fp_addsub u_addsub (
    .a     (unp_a),
    .b     (unp_b),
    .op    (job.op),
    .res   (addsub_res),
    .flags (addsub_flags)
  );

  fp_to_int u_to_int (
    .a     (unp_a),
    .res   (conv_res),
    .flags (conv_flags)
  );

endmodule

//--- fpu_wb_regs.sv
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fpu_wb_regs (
  input  logic                clk,
  input  logic                arst_n,
  input  fpu_pkg::wb_req_t    wb_req,
  output fpu_pkg::wb_rsp_t    wb_rsp,
  output fpu_pkg::fpu_job_t   job,
  input  fpu_pkg::fp_word_u   addsub_res,
  input  fpu_pkg::fpu_flags_t addsub_flags,
  input  fpu_pkg::fp_word_u   conv_res,
  input  fpu_pkg::fpu_flags_t conv_flags
);

  fpu_pkg::fp_word_u   a_q;
  fpu_pkg::fp_word_u   b_q;
  fpu_pkg::fpu_job_t   job_q;
  fpu_pkg::fp_word_u   res_q;
  fpu_pkg::fpu_flags_t flags_q;
  fpu_pkg::fp_word_u   res_sel;
  fpu_pkg::fpu_flags_t flags_sel;
  logic                busy;      // job registered, result not yet captured
  logic                ack_q;
  logic [31:0]         dat_r_q;
  logic                req;
  logic                stall;
  logic                accept;
  logic                is_op;
  logic                is_res;
  logic                is_stat;

  assign req     = wb_req.cyc & wb_req.stb & ~ack_q;  // no second ack for the same cycle
  assign is_op   = wb_req.adr == `FPU_REG_OP;
  assign is_res  = wb_req.adr == `FPU_REG_RES;
  assign is_stat = wb_req.adr == `FPU_REG_STAT;

  // op writes and result/status reads wait for the job in flight
  assign stall  = busy & ((is_op & wb_req.we) | ((is_res | is_stat) & ~wb_req.we));
  assign accept = req & ~stall;

  // core output picked by the op of the job register
  assign res_sel   = job_q.op == fpu_pkg::op_float_to_int ? conv_res : addsub_res;
  assign flags_sel = job_q.op == fpu_pkg::op_float_to_int ? conv_flags : addsub_flags;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q   <= 1'b0;
      busy    <= 1'b0;
      dat_r_q <= '0;
      a_q     <= '0;
      b_q     <= '0;
      job_q   <= '0;
      res_q   <= '0;
      flags_q <= '0;
    end else begin
      ack_q <= accept;  // single registered pulse
      if (busy) begin
        res_q   <= res_sel;    // core settled during the busy cycle
        flags_q <= flags_sel;
        busy    <= 1'b0;
      end
      if (accept && wb_req.we) begin
        case (wb_req.adr)
          `FPU_REG_A: a_q <= wb_req.dat_w;
          `FPU_REG_B: b_q <= wb_req.dat_w;
          `FPU_REG_OP: begin
            job_q.a  <= a_q;
            job_q.b  <= b_q;
            job_q.op <= fpu_pkg::fpu_op_e'(wb_req.dat_w[1:0]);  // low bits only
            busy     <= 1'b1;
          end
          default: ;  // result and status are read only
        endcase
      end
      if (accept && !wb_req.we) begin
        case (wb_req.adr)
          `FPU_REG_A:    dat_r_q <= a_q;
          `FPU_REG_B:    dat_r_q <= b_q;
          `FPU_REG_OP:   dat_r_q <= {30'd0, job_q.op};
          `FPU_REG_RES:  dat_r_q <= res_q;
          `FPU_REG_STAT: dat_r_q <= {29'd0, flags_q.overflow, flags_q.invalid, busy};
          default:       dat_r_q <= '0;  // unmapped words
        endcase
      end
    end
  end

  assign job          = job_q;
  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_r_q;

endmodule

//--- fp_to_int.sv
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fp_to_int (
  input  fpu_pkg::fp_unpacked_t a,
  output fpu_pkg::fp_word_u     res,
  output fpu_pkg::fpu_flags_t   flags
);

  localparam int MW  = `FPU_MAN_W + 1;  // mantissa with hidden bit
  localparam int IW  = 32;              // integer result width
  localparam int EXW = `FPU_EXP_W + 2;  // signed unbiased exponent
  localparam int WW  = MW + IW - 1;     // shifter width

  logic signed [EXW-1:0] e_unb;
  logic [WW-1:0]         wide;
  logic [IW-1:0]         int_mag;

  assign e_unb = $signed({2'b00, a.exp}) - EXW'(`FPU_BIAS);

  // 1.m * 2^e, drop everything below the binary point
  assign wide    = {{(IW - 1){1'b0}}, a.man} << e_unb[4:0];
  assign int_mag = {1'b0, wide[WW-2:MW-1]};

  always_comb begin
    res   = '0;  // |x| < 1 truncates to 0
    flags = '0;  // overflow never set here
    if (a.nan) begin
      flags.invalid = 1'b1;  // nan converts to 0
    end else if (a.inf || e_unb >= EXW'(IW - 1)) begin
      res = a.sign ? `FPU_INT_MIN : `FPU_INT_MAX;  // magnitude 2^31 or more
    end else if (e_unb >= 0) begin
      res.i = a.sign ? -int_mag : int_mag;
    end
  end

endmodule

//--- fp_addsub.sv
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fp_addsub (
  input  fpu_pkg::fp_unpacked_t a,
  input  fpu_pkg::fp_unpacked_t b,
  input  fpu_pkg::fpu_op_e      op,
  output fpu_pkg::fp_word_u     res,
  output fpu_pkg::fpu_flags_t   flags
);

  localparam int MW = `FPU_MAN_W + 1;   // mantissa with hidden bit
  localparam int AW = MW + `FPU_GRD_W;  // aligned mantissa plus g/r/s
  localparam int SW = AW + 2;           // plus carry and sign positions
  localparam int XW = MW + AW - 1;      // alignment shifter, nothing falls off
  localparam int EW = `FPU_EXP_W + 1;   // one spare bit to see overflow

  logic                  b_sign;        // b sign after the op is applied
  logic                  a_small;       // a has the smaller exponent
  logic [`FPU_EXP_W-1:0] e_diff;
  logic [`FPU_EXP_W-1:0] d_sat;
  logic [MW-1:0]         m_big;
  logic [MW-1:0]         m_small;
  logic                  s_big;
  logic                  s_small;
  logic [XW-1:0]         m_shift;
  logic [AW-1:0]         al_small;
  logic [SW-1:0]         op_big;
  logic [SW-1:0]         op_small;
  logic [SW-1:0]         sum;
  logic [SW-1:0]         mag;
  logic                  s_res;
  logic [EW-1:0]         e_max;
  logic [EW-1:0]         e_pre;
  logic [SW-1:0]         m_pre;
  logic [4:0]            lz;
  logic [EW-1:0]         n_lim;
  logic [EW-1:0]         n_shamt;
  logic [SW-1:0]         m_norm;
  logic [EW-1:0]         e_norm;
  logic                  grd;
  logic                  rest;
  logic                  rnd_up;
  logic [MW:0]           m_rnd;
  logic [EW-1:0]         e_out;
  logic [`FPU_MAN_W-1:0] frac;
  logic                  ovf;

  // leading zeros of the aligned field, AW when empty
  function automatic logic [4:0] lzc(input logic [AW-1:0] v);
    logic [4:0] n;
    n = 5'(AW);
    for (int i = 0; i < AW; i++) begin
      if (v[i]) n = 5'(AW - 1 - i);  // highest set bit wins
    end
    return n;
  endfunction

  assign b_sign  = b.sign ^ (op == fpu_pkg::op_sub);  // a - b is a + (-b)
  assign a_small = a.exp < b.exp;
  assign e_diff  = a_small ? b.exp - a.exp : a.exp - b.exp;
  assign d_sat   = e_diff > `FPU_EXP_W'(AW - 1) ? `FPU_EXP_W'(AW - 1) : e_diff;

  assign m_big   = a_small ? b.man : a.man;
  assign m_small = a_small ? a.man : b.man;
  assign s_big   = a_small ? b_sign : a.sign;
  assign s_small = a_small ? a.sign : b_sign;
  assign e_max   = {1'b0, a_small ? b.exp : a.exp};

  // align the smaller one, every bit below the round position ends in sticky
  assign m_shift  = {m_small, {(AW - 1){1'b0}}} >> d_sat;
  assign al_small = {m_shift[XW-1 -: AW-1], |m_shift[MW-1:0]};

  assign op_big   = {2'b00, m_big, {`FPU_GRD_W{1'b0}}};
  assign op_small = {2'b00, al_small};

  // two's complement add, top bit is the result sign
  assign sum   = (s_big ? -op_big : op_big) + (s_small ? -op_small : op_small);
  assign s_res = sum[SW-1];
  assign mag   = s_res ? -sum : sum;

  // carry out of the hidden position shifts right, sticky kept
  assign m_pre = mag[AW] ? (mag >> 1) | SW'(mag[0]) : mag;
  assign e_pre = e_max + EW'(mag[AW]);

  // left shift stops at exponent 1 so the result may stay subnormal
  assign lz      = lzc(m_pre[AW-1:0]);
  assign n_lim   = e_pre - EW'(1);
  assign n_shamt = EW'(lz) < n_lim ? EW'(lz) : n_lim;
  assign m_norm  = m_pre << n_shamt;
  assign e_norm  = e_pre - n_shamt;

  // nearest even
  assign grd    = m_norm[`FPU_GRD_W-1];
  assign rest   = |m_norm[`FPU_GRD_W-2:0];
  assign rnd_up = grd & (rest | m_norm[`FPU_GRD_W]);
  assign m_rnd  = {1'b0, m_norm[AW-1:`FPU_GRD_W]} + (MW + 1)'(rnd_up);

  // rounding carry renormalizes, missing hidden bit means exponent field 0
  assign e_out = m_rnd[MW]   ? e_norm + EW'(1) :
                 m_rnd[MW-1] ? e_norm          : '0;
  assign frac  = m_rnd[MW] ? m_rnd[MW-1:1] : m_rnd[MW-2:0];
  assign ovf   = e_out >= {1'b0, {`FPU_EXP_W{1'b1}}};

  always_comb begin
    res   = '0;  // also the +0 of an exact cancellation
    flags = '0;
    if (a.nan || b.nan) begin
      res           = `FPU_QNAN;
      flags.invalid = 1'b1;
    end else if (a.inf && b.inf && (a.sign != b_sign)) begin
      res           = `FPU_QNAN;  // inf - inf
      flags.invalid = 1'b1;
    end else if (a.inf) begin
      res.f.sign = a.sign;
      res.f.exp  = '1;
    end else if (b.inf) begin
      res.f.sign = b_sign;
      res.f.exp  = '1;
    end else if (mag != '0) begin
      res.f.sign = s_res;
      if (ovf) begin
        res.f.exp      = '1;  // signed infinity
        flags.overflow = 1'b1;
      end else begin
        res.f.exp = e_out[`FPU_EXP_W-1:0];
        res.f.man = frac;
      end
    end
  end

endmodule

//--- fp_unpack.sv
`timescale 1ns/1ps
`include "fpu_cfg.svh"

module fp_unpack (
  input  fpu_pkg::fp_word_u     op_word,
  output fpu_pkg::fp_unpacked_t unp
);

  logic exp_ones;  // exponent field all ones
  logic exp_zero;  // exponent field all zeros
  logic man_zero;  // stored fraction is zero

  assign exp_ones = op_word.f.exp == '1;
  assign exp_zero = op_word.f.exp == '0;
  assign man_zero = op_word.f.man == '0;

  // classification from the two fields
  assign unp.nan       = exp_ones & ~man_zero;
  assign unp.inf       = exp_ones &  man_zero;
  assign unp.zero      = exp_zero &  man_zero;
  assign unp.subnormal = exp_zero & ~man_zero;

  assign unp.sign = op_word.f.sign;

  // subnormals live at 2^-126 like the smallest normal
  // so they share effective exponent 1, a true zero keeps 0
  assign unp.exp = unp.subnormal ? `FPU_EXP_W'(1) : op_word.f.exp;

  // hidden one only when the exponent field is nonzero
  assign unp.man = {~exp_zero, op_word.f.man};

endmodule

//--- fpu_pkg.sv
`include "fpu_cfg.svh"

package fpu_pkg;

  typedef enum logic [1:0] {
    op_add          = 2'd0,
    op_sub          = 2'd1,
    op_float_to_int = 2'd2
  } fpu_op_e;

  typedef struct packed {
    logic                  sign;
    logic [`FPU_EXP_W-1:0] exp;
    logic [`FPU_MAN_W-1:0] man;
  } fp_fields_t;

  // result word is a float for add/sub and a signed integer for conversion
  typedef union packed {
    fp_fields_t                           f;
    logic signed [`FPU_EXP_W+`FPU_MAN_W:0] i;
  } fp_word_u;

  typedef struct packed {
    logic                  nan;
    logic                  inf;
    logic                  zero;
    logic                  subnormal;
    logic                  sign;
    logic [`FPU_EXP_W-1:0] exp; // effective exponent, 1 for subnormals
    logic [`FPU_MAN_W:0]   man; // hidden bit on top
  } fp_unpacked_t;

  typedef struct packed {
    fp_word_u a;
    fp_word_u b;
    fpu_op_e  op;
  } fpu_job_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
  } fpu_flags_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`FPU_ADR_W-1:0] adr;
    logic [31:0]           dat_w;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

endpackage

//--- fpu_cfg.svh
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// binary32 field layout
`define FPU_EXP_W 8
`define FPU_MAN_W 23
`define FPU_BIAS  127

// guard, round and sticky below the mantissa lsb
`define FPU_GRD_W 3

// wishbone word addresses
`define FPU_ADR_W    3
`define FPU_REG_A    3'd0
`define FPU_REG_B    3'd1
`define FPU_REG_OP   3'd2
`define FPU_REG_RES  3'd3
`define FPU_REG_STAT 3'd4

// fixed result words
`define FPU_QNAN    32'h7FC0_0000
`define FPU_INT_MAX 32'h7FFF_FFFF
`define FPU_INT_MIN 32'h8000_0000

`endif
